// ==== source/rv_defs.svh ====
// RV32I encoding constants for the core
// Opcode values, ALU and branch funct3 codes, funct7 alternate value
// Start address after reset

`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Major opcodes
`define OPCODE_BRANCH  7'h63
`define OPCODE_JALR    7'h67
`define OPCODE_JAL     7'h6f
`define OPCODE_LUI     7'h37
`define OPCODE_AUIPC   7'h17
`define OPCODE_OP_IMM  7'h13
`define OPCODE_OP      7'h33
`define OPCODE_LOAD    7'h03
`define OPCODE_STORE   7'h23
`define OPCODE_FENCE   7'h0f

// ALU funct3
`define FUNCT3_ADD_SUB 3'b000
`define FUNCT3_SLL     3'b001
`define FUNCT3_SLT     3'b010
`define FUNCT3_SLTU    3'b011
`define FUNCT3_XOR     3'b100
`define FUNCT3_SRL_SRA 3'b101
`define FUNCT3_OR      3'b110
`define FUNCT3_AND     3'b111

// Branch funct3
`define FUNCT3_BEQ     3'b000
`define FUNCT3_BNE     3'b001
`define FUNCT3_BLT     3'b100
`define FUNCT3_BGE     3'b101
`define FUNCT3_BLTU    3'b110
`define FUNCT3_BGEU    3'b111

// Selects sub and sra
`define FUNCT7_ALT     7'b0100000

`define RESET_PC       32'h0000_0000

`endif

// ==== source/rv_pkg.sv ====
// Shared types of the RV32I core
// Word typedefs, opcode classes, decoded instruction, retire record
// and the sequencer states

package rv_pkg;

   // Meaningful widths
   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [4:0]  reg_index_t;
   typedef logic [6:0]  opcode_t;

   // One flag per opcode class, exactly one set for a known opcode
   typedef struct packed {
      logic branch;
      logic jalr;
      logic jal;
      logic lui;
      logic auipc;
      logic reg_imm;
      logic reg_reg;
      logic load;
      logic store;
      logic fence;
   } op_class_t;

   // Output of the decode stage
   typedef struct packed {
      op_class_t  op_class;
      reg_index_t rd;
      reg_index_t rs1;
      reg_index_t rs2;
      logic [2:0] funct3;
      logic       alt;
      word_t      imm;
      logic       legal;
   } decoded_t;

   // One retired instruction on the trace port
   typedef struct packed {
      addr_t      pc;
      reg_index_t rd;
      word_t      rd_value;
      logic       rd_write;
   } retire_t;

   typedef enum logic [1:0] {
      SEQ_FETCH,
      SEQ_DECODE,
      SEQ_EXECUTE,
      SEQ_HALT
   } seq_state_t;

endpackage

// ==== source/instr_fetch.sv ====
// Instruction fetch unit
// PC register, core sequencer FSM and Wishbone classic read master

`timescale 1ns/1ns
`include "rv_defs.svh"

module instr_fetch import rv_pkg::*; (
   input  logic       clock,
   input  logic       rst_n,
   output logic       wb_cyc,
   output logic       wb_stb,
   output addr_t      wb_adr,
   input  word_t      wb_dat,
   input  logic       wb_ack,
   input  addr_t      next_pc,
   input  logic       legal,
   output word_t      instruction,
   output addr_t      pc,
   output seq_state_t state
);

   seq_state_t state_next;
   logic       bus_active;
   logic       fetch_done;

   // Ack only counts while our cycle is open
   assign fetch_done = (state == SEQ_FETCH) && bus_active && wb_ack;

   always_comb begin
      state_next = state;
      case (state)
         SEQ_FETCH: begin
            if (fetch_done) begin
               state_next = SEQ_DECODE;
            end
         end
         SEQ_DECODE:  state_next = SEQ_EXECUTE;
         SEQ_EXECUTE: state_next = legal ? SEQ_FETCH : SEQ_HALT;
         default:     state_next = SEQ_HALT;
      endcase
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         state      <= SEQ_FETCH;
         pc         <= `RESET_PC;
         bus_active <= 1'b0;
      end else begin
         state      <= state_next;
         // Cycle opens with the fetch state, closes after ack
         bus_active <= (state_next == SEQ_FETCH);
         if (state == SEQ_EXECUTE && legal) begin
            pc <= next_pc;
         end
      end
   end

   // Word held until the next fetch completes
   always_ff @(posedge clock) begin
      if (fetch_done) begin
         instruction <= wb_dat;
      end
   end

   assign wb_cyc = bus_active;
   assign wb_stb = bus_active;
   assign wb_adr = pc;

endmodule

// ==== source/decode.sv ====
// Instruction decoder
// Registered one-hot opcode classes, register fields, funct bits
// and the immediate selected by instruction format

`timescale 1ns/1ns
`include "rv_defs.svh"

module decode import rv_pkg::*; (
   input  logic     clock,
   input  logic     rst_n,
   input  word_t    instruction,
   output decoded_t decoded
);

   opcode_t    opcode;
   op_class_t  class_d;
   op_class_t  class_q;
   word_t      imm_d;
   word_t      imm_q;
   reg_index_t rd_q;
   reg_index_t rs1_q;
   reg_index_t rs2_q;
   logic [2:0] funct3_q;
   logic       alt_q;
   logic       legal;

   assign opcode = instruction[6:0];

   always_comb begin
      class_d.branch  = (opcode == `OPCODE_BRANCH);
      class_d.jalr    = (opcode == `OPCODE_JALR);
      class_d.jal     = (opcode == `OPCODE_JAL);
      class_d.lui     = (opcode == `OPCODE_LUI);
      class_d.auipc   = (opcode == `OPCODE_AUIPC);
      class_d.reg_imm = (opcode == `OPCODE_OP_IMM);
      class_d.reg_reg = (opcode == `OPCODE_OP);
      class_d.load    = (opcode == `OPCODE_LOAD);
      class_d.store   = (opcode == `OPCODE_STORE);
      class_d.fence   = (opcode == `OPCODE_FENCE);
   end

   // Immediate format by class, I-type otherwise
   always_comb begin
      if (class_d.store) begin
         imm_d = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
      end else if (class_d.branch) begin
         imm_d = {{19{instruction[31]}}, instruction[31], instruction[7],
                  instruction[30:25], instruction[11:8], 1'b0};
      end else if (class_d.lui || class_d.auipc) begin
         imm_d = {instruction[31:12], 12'b0};
      end else if (class_d.jal) begin
         imm_d = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                  instruction[20], instruction[30:21], 1'b0};
      end else begin
         imm_d = {{20{instruction[31]}}, instruction[31:20]};
      end
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         class_q <= '0;
      end else begin
         class_q <= class_d;
      end
   end

   always_ff @(posedge clock) begin
      rd_q     <= instruction[11:7];
      rs1_q    <= instruction[19:15];
      rs2_q    <= instruction[24:20];
      funct3_q <= instruction[14:12];
      alt_q    <= (instruction[31:25] == `FUNCT7_ALT);
      imm_q    <= imm_d;
   end

   // Loads and stores are decoded but not executed
   assign legal = class_q.branch | class_q.jalr | class_q.jal | class_q.lui |
                  class_q.auipc | class_q.reg_imm | class_q.reg_reg | class_q.fence;

   assign decoded = '{op_class: class_q, rd: rd_q, rs1: rs1_q, rs2: rs2_q,
                      funct3: funct3_q, alt: alt_q, imm: imm_q, legal: legal};

endmodule

// ==== source/register_file.sv ====
// General purpose register file
// x1 to x31 with reset, x0 hardwired to zero
// Two combinational read ports, one clocked write port

`timescale 1ns/1ns

module register_file import rv_pkg::*; (
   input  logic       clock,
   input  logic       rst_n,
   input  reg_index_t rs1,
   input  reg_index_t rs2,
   output word_t      rs1_value,
   output word_t      rs2_value,
   input  logic       write_enable,
   input  reg_index_t write_index,
   input  word_t      write_value
);

   word_t regs [1:31];

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (write_enable && write_index != '0) begin
         regs[write_index] <= write_value;
      end
   end

   // x0 never stored
   assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/execute.sv ====
// Execute stage
// ALU for register and immediate forms, branch comparator,
// next PC selection, writeback value and the retire record

`timescale 1ns/1ns
`include "rv_defs.svh"

module execute import rv_pkg::*; (
   input  decoded_t   decoded,
   input  addr_t      pc,
   input  seq_state_t state,
   input  word_t      rs1_value,
   input  word_t      rs2_value,
   output addr_t      next_pc,
   output logic       write_enable,
   output word_t      write_value,
   output logic       retire_valid,
   output retire_t    retire
);

   word_t      operand_b;
   word_t      alu_result;
   logic [4:0] shamt;
   logic       is_sub;
   logic       branch_taken;
   logic       writes_rd;
   logic       rd_written;
   logic       in_execute;
   addr_t      pc_plus4;
   addr_t      pc_target;

   assign operand_b = decoded.op_class.reg_reg ? rs2_value : decoded.imm;
   assign shamt     = operand_b[4:0];
   // addi has no subtract form
   assign is_sub    = decoded.op_class.reg_reg && decoded.alt;

   always_comb begin
      case (decoded.funct3)
         `FUNCT3_ADD_SUB: alu_result = is_sub ? rs1_value - operand_b
                                              : rs1_value + operand_b;
         `FUNCT3_SLL:     alu_result = rs1_value << shamt;
         `FUNCT3_SLT:     alu_result = {31'b0, $signed(rs1_value) < $signed(operand_b)};
         `FUNCT3_SLTU:    alu_result = {31'b0, rs1_value < operand_b};
         `FUNCT3_XOR:     alu_result = rs1_value ^ operand_b;
         `FUNCT3_SRL_SRA: alu_result = decoded.alt ? word_t'($signed(rs1_value) >>> shamt)
                                                   : rs1_value >> shamt;
         `FUNCT3_OR:      alu_result = rs1_value | operand_b;
         default:         alu_result = rs1_value & operand_b;
      endcase
   end

   // Branch condition
   always_comb begin
      case (decoded.funct3)
         `FUNCT3_BEQ:  branch_taken = (rs1_value == rs2_value);
         `FUNCT3_BNE:  branch_taken = (rs1_value != rs2_value);
         `FUNCT3_BLT:  branch_taken = ($signed(rs1_value) < $signed(rs2_value));
         `FUNCT3_BGE:  branch_taken = ($signed(rs1_value) >= $signed(rs2_value));
         `FUNCT3_BLTU: branch_taken = (rs1_value < rs2_value);
         `FUNCT3_BGEU: branch_taken = (rs1_value >= rs2_value);
         default:      branch_taken = 1'b0;
      endcase
   end

   assign pc_plus4  = pc + 32'd4;
   assign pc_target = pc + decoded.imm;

   always_comb begin
      if (decoded.op_class.jalr) begin
         next_pc = (rs1_value + decoded.imm) & ~32'd1;
      end else if (decoded.op_class.jal || (decoded.op_class.branch && branch_taken)) begin
         next_pc = pc_target;
      end else begin
         next_pc = pc_plus4;
      end
   end

   always_comb begin
      if (decoded.op_class.lui) begin
         write_value = decoded.imm;
      end else if (decoded.op_class.auipc) begin
         write_value = pc_target;
      end else if (decoded.op_class.jal || decoded.op_class.jalr) begin
         write_value = pc_plus4;
      end else begin
         write_value = alu_result;
      end
   end

   assign writes_rd = decoded.op_class.lui | decoded.op_class.auipc | decoded.op_class.jal |
                      decoded.op_class.jalr | decoded.op_class.reg_imm |
                      decoded.op_class.reg_reg;
   // Writes to x0 are dropped
   assign rd_written   = writes_rd && (decoded.rd != '0);
   assign in_execute   = (state == SEQ_EXECUTE) && decoded.legal;
   assign write_enable = in_execute && rd_written;
   assign retire_valid = in_execute;

   assign retire = '{pc: pc, rd: decoded.rd, rd_value: write_value, rd_write: rd_written};

endmodule

// ==== source/core_top.sv ====
// Top level of the multi-cycle RV32I core
// Fetch, decode, register file and execute with the retire trace port

`timescale 1ns/1ns

module core_top import rv_pkg::*; (
   input  logic    clock,
   input  logic    rst_n,
   // Wishbone instruction bus
   output logic    wb_cyc,
   output logic    wb_stb,
   output addr_t   wb_adr,
   input  word_t   wb_dat,
   input  logic    wb_ack,
   // Trace
   output logic    retire_valid,
   output retire_t retire,
   output logic    halted
);

   seq_state_t state;
   word_t      instruction;
   addr_t      pc;
   addr_t      next_pc;
   decoded_t   decoded;
   word_t      rs1_value;
   word_t      rs2_value;
   logic       write_enable;
   word_t      write_value;

   instr_fetch i_fetch (
      .clock       (clock),
      .rst_n       (rst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_adr      (wb_adr),
      .wb_dat      (wb_dat),
      .wb_ack      (wb_ack),
      .next_pc     (next_pc),
      .legal       (decoded.legal),
      .instruction (instruction),
      .pc          (pc),
      .state       (state)
   );

   decode i_decode (
      .clock       (clock),
      .rst_n       (rst_n),
      .instruction (instruction),
      .decoded     (decoded)
   );

   // Write index comes from the retire record
   register_file i_regs (
      .clock        (clock),
      .rst_n        (rst_n),
      .rs1          (decoded.rs1),
      .rs2          (decoded.rs2),
      .rs1_value    (rs1_value),
      .rs2_value    (rs2_value),
      .write_enable (write_enable),
      .write_index  (retire.rd),
      .write_value  (write_value)
   );

   execute i_execute (
      .decoded      (decoded),
      .pc           (pc),
      .state        (state),
      .rs1_value    (rs1_value),
      .rs2_value    (rs2_value),
      .next_pc      (next_pc),
      .write_enable (write_enable),
      .write_value  (write_value),
      .retire_valid (retire_valid),
      .retire       (retire)
   );

   assign halted = (state == SEQ_HALT);

endmodule

// ==== verification/clock_gen.sv ====
// Testbench clock and reset generator
// Free-running clock, active low reset held for a number of cycles

`timescale 1ns/1ns

module clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 5
) (
   output logic clock,
   output logic rst_n
);

   initial begin
      clock = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clock = ~clock;
      end
   end

   // Released on a falling edge like every other input
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock);
      @(negedge clock);
      rst_n = 1'b1;
   end

endmodule

// ==== verification/core_tb.sv ====
// Testbench for the RV32I core
// Wishbone instruction memory with random wait states, retire trace
// checks against the vector file, halt check and cycle limit

`timescale 1ns/1ns

module core_tb import rv_pkg::*; ();

   localparam int RESET_CYCLES = 5;
   localparam int MAX_WAIT     = 3;
   localparam int HALT_WATCH   = 20;
   localparam int VEC_DEPTH    = 256;

   logic        clock;
   logic        rst_n;
   logic        wb_cyc;
   logic        wb_stb;
   addr_t       wb_adr;
   word_t       wb_dat = '0;
   logic        wb_ack = 1'b0;
   logic        retire_valid;
   retire_t     retire;
   logic        halted;

   // Vector file image and its layout
   logic [31:0] vectors [0:VEC_DEPTH-1];
   int unsigned program_words;
   int unsigned record_count;
   int unsigned record_base;
   int unsigned cycle_limit;
   addr_t       halt_pc;

   // Memory model state
   logic [31:0] rand_state   = 32'd262;
   logic        request_open = 1'b0;
   int unsigned wait_left    = 0;
   int unsigned word_index;
   addr_t       last_fetch   = '0;

   int unsigned next_record  = 0;
   int unsigned cycle_count  = 0;

   clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) i_clock (
      .clock (clock),
      .rst_n (rst_n)
   );

   core_top i_dut (
      .clock        (clock),
      .rst_n        (rst_n),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_adr       (wb_adr),
      .wb_dat       (wb_dat),
      .wb_ack       (wb_ack),
      .retire_valid (retire_valid),
      .retire       (retire),
      .halted       (halted)
   );

   task automatic end_with_failure();
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped at the first error");
   endtask

   function automatic logic [31:0] next_random();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state;
   endfunction

   function automatic retire_t expected_record(input int unsigned index);
      int unsigned base;
      retire_t     rec;
      base         = record_base + 4 * index;
      rec.pc       = vectors[base];
      rec.rd       = vectors[base + 1][4:0];
      rec.rd_value = vectors[base + 2];
      rec.rd_write = vectors[base + 3][0];
      return rec;
   endfunction

   function automatic string format_retire(input retire_t rec);
      return $sformatf("pc=%h rd=x%0d value=%h write=%b",
                       rec.pc, rec.rd, rec.rd_value, rec.rd_write);
   endfunction

   // rd and its value only count when the record writes
   task automatic compare_retire(input string test_name, input retire_t expected,
                                 input retire_t actual);
      logic mismatch;
      mismatch = (actual.pc !== expected.pc) || (actual.rd_write !== expected.rd_write);
      if (expected.rd_write && (actual.rd !== expected.rd ||
                                actual.rd_value !== expected.rd_value)) begin
         mismatch = 1'b1;
      end
      if (mismatch) begin
         $display("** Error: %s expected %s, actual %s", test_name,
                  format_retire(expected), format_retire(actual));
         end_with_failure();
      end
   endtask

   task automatic compare_address(input string test_name, input addr_t expected,
                                  input addr_t actual);
      if (actual !== expected) begin
         $display("** Error: %s expected %h, actual %h", test_name, expected, actual);
         end_with_failure();
      end
   endtask

   // Wishbone slave with 0 to MAX_WAIT wait cycles per read
   always @(negedge clock) begin
      if (wb_cyc && wb_stb && !wb_ack) begin
         if (!request_open) begin
            request_open = 1'b1;
            wait_left    = (next_random() >> 16) % (MAX_WAIT + 1);
         end
         if (wait_left != 0) begin
            wait_left = wait_left - 1;
         end else begin
            word_index = {2'b00, wb_adr[31:2]};
            if (wb_adr[1:0] != 2'b00 || word_index >= program_words) begin
               $display("Error: fetch from %h is outside the program", wb_adr);
               end_with_failure();
            end else begin
               wb_dat       = vectors[word_index + 1];
               wb_ack       = 1'b1;
               last_fetch   = wb_adr;
               request_open = 1'b0;
            end
         end
      end else begin
         wb_ack = 1'b0;
      end
   end

   // Trace sampled mid-cycle
   always @(negedge clock) begin
      if (retire_valid === 1'b1) begin
         if (next_record >= record_count) begin
            $display("Error: pc %h retired after the last expected record", retire.pc);
            end_with_failure();
         end else begin
            compare_retire($sformatf("retire %0d", next_record),
                           expected_record(next_record), retire);
            next_record = next_record + 1;
         end
      end
   end

   always @(posedge clock) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("Error: run did not finish within %0d cycles", cycle_limit);
         end_with_failure();
      end
   end

   initial begin
      $readmemh("verification/core_vectors.txt", vectors);
      program_words = vectors[0];
      record_count  = vectors[program_words + 1];
      record_base   = program_words + 2;
      halt_pc       = vectors[record_base + 4 * record_count];
      // Worst case fetch plus decode and execute per instruction
      cycle_limit   = (record_count + 1) * (3 + MAX_WAIT) + RESET_CYCLES + HALT_WATCH + 20;
      if ($isunknown(vectors[0]) || program_words == 0 ||
          record_base + 4 * record_count >= VEC_DEPTH) begin
         $display("Error: vector file is missing, empty or too long");
         end_with_failure();
      end
      while (halted !== 1'b1) begin
         @(negedge clock);
      end
      if (next_record != record_count) begin
         $display("Error: halted after %0d of %0d expected records",
                  next_record, record_count);
         end_with_failure();
      end
      compare_address("halt pc", halt_pc, last_fetch);
      // Core stays off the bus once halted
      repeat (HALT_WATCH) begin
         @(negedge clock);
         if (wb_cyc !== 1'b0 || wb_stb !== 1'b0 || halted !== 1'b1) begin
            $display("Error: core opened a bus cycle or left the halt state");
            end_with_failure();
         end
      end
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+source
source/rv_pkg.sv
source/instr_fetch.sv
source/decode.sv
source/register_file.sv
source/execute.sv
source/core_top.sv
verification/clock_gen.sv
verification/core_tb.sv

// ==== Makefile ====
# Verilator build and run of the RV32I core testbench
# Any variable can be overridden on the command line

VERILATOR       ?= verilator
TOP             ?= core_tb
FILE_LIST       ?= list.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --timescale 1ns/1ns

.PHONY: simulate clean

# A failing run ends in $fatal, so the binary exits with an error status
simulate:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/core_vectors.txt ====
// Program word count, then program words from address 0, four per line
// Then record count, one retire record per line as pc rd rd_value rd_write, then halt pc
27
00500093 ffd00113 002081b3 40110233
403252b3 0020b333 0f014393 01c15413
123454b7 00001517 0ff0000f 00308463
00108463 00100593 00109463 00209463
00100593 0020c463 00114463 00100593
00115463 0020d463 00100593 00116463
0020e463 00100593 0020f463 00117463
00100593 00c0066f 00100593 00100593
08d00693 00468767 00100593 00100593
00708013 001007b3 00002083
1c
00000000 01 00000005 1 // addi
00000004 02 fffffffd 1
00000008 03 00000002 1 // add
0000000c 04 fffffff8 1 // sub
00000010 05 fffffffe 1 // sra
00000014 06 00000001 1 // sltu
00000018 07 ffffff0d 1 // xori
0000001c 08 0000000f 1 // srli
00000020 09 12345000 1 // lui
00000024 0a 00001024 1 // auipc
00000028 00 00000000 0 // fence
0000002c 00 00000000 0 // beq not taken
00000030 00 00000000 0
00000038 00 00000000 0 // bne
0000003c 00 00000000 0
00000044 00 00000000 0 // blt
00000048 00 00000000 0
00000050 00 00000000 0 // bge
00000054 00 00000000 0
0000005c 00 00000000 0 // bltu
00000060 00 00000000 0
00000068 00 00000000 0 // bgeu
0000006c 00 00000000 0
00000074 0c 00000078 1 // jal
00000080 0d 0000008d 1
00000084 0e 00000088 1 // jalr, odd target
00000090 00 00000000 0 // write to x0
00000094 0f 00000005 1 // x0 still zero
00000098
